// File: files.f
+incdir+src
src/sd_dat_pkg.sv
src/sd_dat_rx_if.sv
src/sd_dat_crc16.sv
src/sd_dat_rx_fsm.sv
src/sd_dat_rx_counter.sv
src/sd_dat_deser.sv
src/sd_dat_crc_check.sv
src/sd_dat_rx_top.sv
tb/tb_sd_dat_rx.sv

// File: Bender.yml
package:
  name: sd_dat_rx

export_include_dirs:
  - src

sources:
  - src/sd_dat_pkg.sv
  - src/sd_dat_rx_if.sv
  - src/sd_dat_crc16.sv
  - src/sd_dat_rx_fsm.sv
  - src/sd_dat_rx_counter.sv
  - src/sd_dat_deser.sv
  - src/sd_dat_crc_check.sv
  - src/sd_dat_rx_top.sv
  - target: test
    files:
      - tb/tb_sd_dat_rx.sv

// File: tb/tb_sd_dat_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sd_dat_rx;

    // one row of the case table
    typedef struct packed {
        logic        width;    // 1: 4-bit lanes
        logic [15:0] bsize;
        logic [15:0] bcount;   // 0 runs endless
        logic [7:0]  hold;     // cycles parked at each gap
        logic        rw_en;
        logic        gclk_en;
        logic [3:0]  bad_crc;  // lanes with one flipped crc bit
        logic        bad_end;
    } case_t;

    localparam int NCASE        = 6;
    localparam int ENDLESS_BLKS = 3;

    logic sd_clk, rstn, sd_rst_i, dat_start_i, rx_en_i, dat_width_i;
    logic dma_rx_buf_rdy_i, blk_gap_stop_i, blk_gap_clk_en_i, read_wait_en_i;
    sd_dat_pkg::lanes_t dat_i;
    sd_dat_pkg::cnt_t   block_size_i, block_count_i;
    logic busy_o, done_o, blk_gap_o, clk_pause_o, read_wait_o, tmout_rx_start_en_o;
    logic dma_rx_wr_o, crc_err_o, end_err_o;
    sd_dat_pkg::byte_t  dma_rx_byte_o;

    case_t              cases [NCASE];
    sd_dat_pkg::lanes_t stream [$];  // card samples of one block
    sd_dat_pkg::byte_t  exp_q [$];
    sd_dat_pkg::byte_t  exp_byte;
    int errs, wr_cnt, crc_cnt, end_cnt, gap_cnt, done_cnt;
    int cycles, limit;
    logic expect_busy;

    sd_dat_rx_top DUT (.*);

    initial begin
        sd_clk = 1'b0;
        forever #10 sd_clk = ~sd_clk;
    end

    task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("[FAIL] %s: got %0h, expected %0h", name, got, exp);
        errs++;
    endtask

    // sd crc-16, x^16 + x^12 + x^5 + 1
    function automatic sd_dat_pkg::crc_t crc16_next(input sd_dat_pkg::crc_t crc, input logic b);
        logic fb;
        sd_dat_pkg::crc_t nxt;
        fb = b ^ crc[15];
        nxt = {crc[14:0], fb};
        nxt[5] = nxt[5] ^ fb;
        nxt[12] = nxt[12] ^ fb;
        return nxt;
    endfunction

    task automatic build_block(input case_t c);
        sd_dat_pkg::crc_t   crc [4];
        sd_dat_pkg::byte_t  b;
        sd_dat_pkg::lanes_t s;
        for (int l = 0; l < 4; l++)
            crc[l] = '0;
        stream.delete();
        stream.push_back(4'h0); // start bit
        for (int k = 0; k < c.bsize; k++) begin
            b = $urandom % 256;
            exp_q.push_back(b);
            for (int j = 0; j < (c.width ? 2 : 8); j++) begin
                if (c.width)
                    s = (j == 0) ? b[7:4] : b[3:0];
                else
                    s = {3'b111, b[7-j]}; // unused lanes idle high
                for (int l = 0; l < 4; l++)
                    crc[l] = crc16_next(crc[l], s[l]);
                stream.push_back(s);
            end
        end
        for (int i = 0; i < 16; i++) begin
            for (int l = 0; l < 4; l++)
                s[l] = crc[l][15-i] ^ (c.bad_crc[l] && i == 9);
            stream.push_back(s);
        end
        stream.push_back(c.bad_end ? 4'hE : 4'hF);
    endtask

    // card side, one sample per strobe while the card clock runs
    task automatic send_block(input case_t c);
        int   idx;
        int   spb;
        logic take;
        logic pause_due;
        idx = 0;
        spb = c.width ? 2 : 8;
        pause_due = 1'b0;
        while (!tmout_rx_start_en_o) begin
            @(posedge sd_clk);
            #2;
        end
        blk_gap_stop_i = c.hold != 0; // park at the gap after this block
        while (idx < stream.size()) begin
            rx_en_i = ($urandom % 4) != 0;
            dma_rx_buf_rdy_i = ($urandom % 2) != 0;
            dat_i = stream[idx];
            #1;
            if (pause_due && !clk_pause_o)
                report_value("clk_pause_o", clk_pause_o, 1'b1);
            take = rx_en_i && !clk_pause_o;
            pause_due = take && idx > 0 && idx <= c.bsize * spb && (idx % spb) == 0;
            @(posedge sd_clk);
            #2;
            if (take)
                idx++;
        end
        rx_en_i = 1'b0;
        dma_rx_buf_rdy_i = 1'b0;
        dat_i = 4'hF;
    endtask

    task automatic hold_gap(input case_t c);
        int wr_before;
        wr_before = wr_cnt;
        // buffer ready and strobes running, still nothing may be written
        rx_en_i = 1'b1;
        dma_rx_buf_rdy_i = 1'b1;
        for (int i = 0; i < c.hold; i++) begin
            #1;
            if (clk_pause_o !== !c.gclk_en)
                report_value("clk_pause_o", clk_pause_o, !c.gclk_en);
            if (i > 0 && read_wait_o !== c.rw_en)
                report_value("read_wait_o", read_wait_o, c.rw_en); // lags by one cycle
            @(posedge sd_clk);
            #2;
        end
        blk_gap_stop_i = 1'b0;
        rx_en_i = 1'b0;
        dma_rx_buf_rdy_i = 1'b0;
        if (wr_cnt != wr_before) begin
            $display("a byte was written while the engine was parked at the block gap");
            errs++;
        end
    endtask

    always @(negedge sd_clk) begin
        if (rstn) begin
            if (busy_o !== expect_busy)
                report_value("busy_o", busy_o, expect_busy);
            if (dma_rx_wr_o) begin
                wr_cnt++;
                if (exp_q.size() == 0) begin
                    $display("write strobe seen with no byte left to expect");
                    errs++;
                end else begin
                    exp_byte = exp_q.pop_front();
                    if (dma_rx_byte_o !== exp_byte)
                        report_value("dma_rx_byte_o", dma_rx_byte_o, exp_byte);
                end
            end
            crc_cnt += crc_err_o;
            end_cnt += end_err_o;
            gap_cnt += blk_gap_o;
            if (done_o) begin
                done_cnt++;
                expect_busy = 1'b0;
            end
        end
    end

    initial begin
        @(posedge sd_clk);
        while (cycles < limit) begin
            @(posedge sd_clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        case_t c;
        int    nblk;
        int    seed;
        int    total_bytes;
        int    total_blks;
        int    exp_crc;
        seed = $urandom(64);
        errs = 0;
        cycles = 0;
        total_bytes = 0;
        total_blks = 0;
        expect_busy = 1'b0;
        rstn = 1'b0;
        sd_rst_i = 1'b0;
        dat_start_i = 1'b0;
        rx_en_i = 1'b0;
        dat_width_i = 1'b0;
        dat_i = 4'hF;
        block_size_i = '0;
        block_count_i = '0;
        dma_rx_buf_rdy_i = 1'b0;
        blk_gap_stop_i = 1'b0;
        blk_gap_clk_en_i = 1'b1;
        read_wait_en_i = 1'b0;
        // width, size, count, hold, read wait, gap clock, bad crc lanes, bad end
        cases[0] = {1'b0, 16'd4, 16'd2, 8'd0, 1'b0, 1'b1, 4'h0, 1'b0};
        cases[1] = {1'b1, 16'd8, 16'd3, 8'd5, 1'b1, 1'b0, 4'h0, 1'b0};
        cases[2] = {1'b1, 16'd3, 16'd2, 8'd4, 1'b0, 1'b1, 4'h4, 1'b0};
        cases[3] = {1'b0, 16'd2, 16'd2, 8'd0, 1'b0, 1'b1, 4'h2, 1'b1};
        cases[4] = {1'b0, 16'd5, 16'd1, 8'd0, 1'b0, 1'b1, 4'h1, 1'b0};
        cases[5] = {1'b1, 16'd4, 16'd0, 8'd2, 1'b1, 1'b1, 4'h0, 1'b0};
        limit = 100;
        for (int n = 0; n < NCASE; n++) begin
            nblk = (cases[n].bcount != 0) ? cases[n].bcount : ENDLESS_BLKS;
            limit += nblk * ((cases[n].bsize * 8 + 20) * 4 + cases[n].hold) + 50;
        end
        repeat (2) @(posedge sd_clk);
        #2;
        rstn = 1'b1;
        for (int n = 0; n < NCASE; n++) begin
            c = cases[n];
            nblk = (c.bcount != 0) ? c.bcount : ENDLESS_BLKS;
            dat_width_i = c.width;
            block_size_i = c.bsize;
            block_count_i = c.bcount;
            read_wait_en_i = c.rw_en;
            blk_gap_clk_en_i = c.gclk_en;
            wr_cnt = 0;
            crc_cnt = 0;
            end_cnt = 0;
            gap_cnt = 0;
            done_cnt = 0;
            @(posedge sd_clk);
            #2;
            dat_start_i = 1'b1;
            @(posedge sd_clk);
            #2;
            dat_start_i = 1'b0;
            expect_busy = 1'b1;
            for (int b = 0; b < nblk; b++) begin
                build_block(c);
                send_block(c);
                if (b < nblk - 1)
                    hold_gap(c);
            end
            if (c.bcount == 0) begin
                blk_gap_stop_i = 1'b0;
                repeat (2) begin
                    @(posedge sd_clk);
                    #2;
                end
                if (!tmout_rx_start_en_o)
                    report_value("tmout_rx_start_en_o", tmout_rx_start_en_o, 1'b1);
                sd_rst_i = 1'b1;
                @(posedge sd_clk);
                #2;
                sd_rst_i = 1'b0;
                expect_busy = 1'b0;
            end else begin
                while (busy_o) begin
                    @(posedge sd_clk);
                    #2;
                end
            end
            @(posedge sd_clk);
            #2;
            // only lanes active in this width can raise a crc error
            exp_crc = ((c.bad_crc & (c.width ? 4'hF : 4'h1)) != 0) ? nblk : 0;
            if (wr_cnt != c.bsize * nblk)
                report_value("dma_rx_wr_o pulses", wr_cnt, c.bsize * nblk);
            if (crc_cnt != exp_crc)
                report_value("crc_err_o pulses", crc_cnt, exp_crc);
            if (end_cnt != (c.bad_end ? nblk : 0))
                report_value("end_err_o pulses", end_cnt, c.bad_end ? nblk : 0);
            if (gap_cnt != nblk)
                report_value("blk_gap_o pulses", gap_cnt, nblk);
            if (done_cnt != (c.bcount != 0))
                report_value("done_o pulses", done_cnt, c.bcount != 0);
            exp_q.delete();
            total_bytes += wr_cnt;
            total_blks += gap_cnt;
        end
        $display("%0d bytes in %0d blocks received, %0d errors", total_bytes, total_blks, errs);
        if (errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src/sd_dat_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module sd_dat_rx_top (
    input  logic               sd_clk,
    input  logic               rstn,
    input  logic               sd_rst_i,          // soft reset back to idle
    input  logic               dat_start_i,
    input  logic               rx_en_i,           // sampling strobe
    input  logic               dat_width_i,
    input  sd_dat_pkg::lanes_t dat_i,
    input  sd_dat_pkg::cnt_t   block_size_i,
    input  sd_dat_pkg::cnt_t   block_count_i,
    input  logic               dma_rx_buf_rdy_i,
    input  logic               blk_gap_stop_i,
    input  logic               blk_gap_clk_en_i,
    input  logic               read_wait_en_i,
    output logic               busy_o,
    output logic               done_o,
    output logic               blk_gap_o,
    output logic               clk_pause_o,
    output logic               read_wait_o,       // drive dat2 low
    output logic               tmout_rx_start_en_o,
    output sd_dat_pkg::byte_t  dma_rx_byte_o,
    output logic               dma_rx_wr_o,
    output logic               crc_err_o,
    output logic               end_err_o
);

    sd_dat_rx_if bus ();

    sd_dat_rx_fsm u_fsm (
        .sd_clk              (sd_clk),
        .rstn                (rstn),
        .sd_rst_i            (sd_rst_i),
        .dat_start_i         (dat_start_i),
        .rx_en_i             (rx_en_i),
        .dat_width_i         (dat_width_i),
        .dat_i               (dat_i),
        .dma_rx_buf_rdy_i    (dma_rx_buf_rdy_i),
        .blk_gap_stop_i      (blk_gap_stop_i),
        .blk_gap_clk_en_i    (blk_gap_clk_en_i),
        .read_wait_en_i      (read_wait_en_i),
        .bus                 (bus.ctrl),
        .busy_o              (busy_o),
        .done_o              (done_o),
        .blk_gap_o           (blk_gap_o),
        .clk_pause_o         (clk_pause_o),
        .read_wait_o         (read_wait_o),
        .tmout_rx_start_en_o (tmout_rx_start_en_o)
    );

    sd_dat_rx_counter u_counter (
        .sd_clk           (sd_clk),
        .rstn             (rstn),
        .sd_rst_i         (sd_rst_i),
        .rx_en_i          (rx_en_i),
        .dat_width_i      (dat_width_i),
        .dma_rx_buf_rdy_i (dma_rx_buf_rdy_i),
        .block_size_i     (block_size_i),
        .block_count_i    (block_count_i),
        .bus              (bus.cnt)
    );

    sd_dat_deser u_deser (
        .sd_clk           (sd_clk),
        .rstn             (rstn),
        .rx_en_i          (rx_en_i),
        .dat_width_i      (dat_width_i),
        .dma_rx_buf_rdy_i (dma_rx_buf_rdy_i),
        .dat_i            (dat_i),
        .bus              (bus.data),
        .dma_rx_byte_o    (dma_rx_byte_o),
        .dma_rx_wr_o      (dma_rx_wr_o)
    );

    sd_dat_crc_check u_crc_check (
        .sd_clk      (sd_clk),
        .rstn        (rstn),
        .sd_rst_i    (sd_rst_i),
        .rx_en_i     (rx_en_i),
        .dat_width_i (dat_width_i),
        .dat_i       (dat_i),
        .bus         (bus.data),
        .crc_err_o   (crc_err_o),
        .end_err_o   (end_err_o)
    );

endmodule

`default_nettype wire

// File: src/sd_dat_crc_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_settings.svh"

module sd_dat_crc_check (
    input  logic               sd_clk,
    input  logic               rstn,
    input  logic               sd_rst_i,
    input  logic               rx_en_i,
    input  logic               dat_width_i,
    input  sd_dat_pkg::lanes_t dat_i,
    sd_dat_rx_if.data          bus,
    output logic               crc_err_o,
    output logic               end_err_o
);

    sd_dat_pkg::crc_t   crc [`SD_LANES];
    sd_dat_pkg::lanes_t act_lanes;
    sd_dat_pkg::lanes_t lane_en;
    sd_dat_pkg::lanes_t lane_mis;  // received crc bit differs
    logic               crc_clr, data_stb, end_stb;
    logic               mis_q;

    assign act_lanes = dat_width_i ? '1 : sd_dat_pkg::lanes_t'(1);
    assign crc_clr   = bus.state == sd_dat_pkg::RX_START_BIT;
    assign data_stb  = (bus.state == sd_dat_pkg::RX_DATA_BYTE) && rx_en_i;
    assign end_stb   = (bus.state == sd_dat_pkg::RX_END_BIT) && rx_en_i;
    assign lane_en   = data_stb ? act_lanes : '0;

    for (genvar g = 0; g < `SD_LANES; g++) begin : g_lane
        sd_dat_crc16 u_crc (
            .sd_clk (sd_clk),
            .rstn   (rstn),
            .clr_i  (crc_clr),
            .en_i   (lane_en[g]),
            .din_i  (dat_i[g]),
            .crc_o  (crc[g])
        );
        // crc goes out msb first
        assign lane_mis[g] = dat_i[g] != crc[g][`SD_CRC_LEN - 1 - bus.crc_idx];
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            mis_q     <= 1'b0;
            crc_err_o <= 1'b0;
            end_err_o <= 1'b0;
        end else if (sd_rst_i) begin
            mis_q     <= 1'b0;
            crc_err_o <= 1'b0;
            end_err_o <= 1'b0;
        end else begin
            if (crc_clr)
                mis_q <= 1'b0;
            else if ((bus.state == sd_dat_pkg::RX_CRC) && rx_en_i && |(lane_mis & act_lanes))
                mis_q <= 1'b1; // sticky for the block
            crc_err_o <= end_stb && mis_q;
            end_err_o <= end_stb && |(~dat_i & act_lanes); // any active lane low
        end
    end

endmodule

`default_nettype wire

// File: src/sd_dat_deser.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_settings.svh"

module sd_dat_deser (
    input  logic               sd_clk,
    input  logic               rstn,
    input  logic               rx_en_i,
    input  logic               dat_width_i,
    input  logic               dma_rx_buf_rdy_i,
    input  sd_dat_pkg::lanes_t dat_i,
    sd_dat_rx_if.data          bus,
    output sd_dat_pkg::byte_t  dma_rx_byte_o,
    output logic               dma_rx_wr_o
);

    sd_dat_pkg::byte_t shift_q;
    logic              byte_take;

    assign byte_take = (bus.state == sd_dat_pkg::DMA_RX_BYTE_WR) && dma_rx_buf_rdy_i;

    // msb first, wide mode moves a nibble per strobe
    always_ff @(posedge sd_clk) begin
        if ((bus.state == sd_dat_pkg::RX_DATA_BYTE) && rx_en_i) begin
            if (dat_width_i)
                shift_q <= {shift_q[`SD_BYTE_W-`SD_LANES-1:0], dat_i};
            else
                shift_q <= {shift_q[`SD_BYTE_W-2:0], dat_i[0]};
        end
        if (byte_take)
            dma_rx_byte_o <= shift_q; // held until the next write
    end

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn)
            dma_rx_wr_o <= 1'b0;
        else
            dma_rx_wr_o <= byte_take;
    end

endmodule

`default_nettype wire

// File: src/sd_dat_rx_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_settings.svh"

module sd_dat_rx_counter (
    input  logic             sd_clk,
    input  logic             rstn,
    input  logic             sd_rst_i,
    input  logic             rx_en_i,
    input  logic             dat_width_i,
    input  logic             dma_rx_buf_rdy_i,
    input  sd_dat_pkg::cnt_t block_size_i,
    input  sd_dat_pkg::cnt_t block_count_i, // 0 means endless
    sd_dat_rx_if.cnt         bus
);

    localparam int IDX_W = $clog2(`SD_CRC_LEN);

    logic [2:0]       bit_cnt;
    sd_dat_pkg::cnt_t byte_cnt;  // doubles as crc index
    sd_dat_pkg::cnt_t blk_cnt;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            blk_cnt  <= '0;
        end else if (sd_rst_i || bus.state == sd_dat_pkg::IDLE) begin
            bit_cnt  <= '0;
            byte_cnt <= '0;
            blk_cnt  <= '0;
        end else begin
            case (bus.state)
                sd_dat_pkg::RX_START_BIT: begin
                    bit_cnt  <= '0; // fresh block
                    byte_cnt <= '0;
                end
                sd_dat_pkg::RX_DATA_BYTE: begin
                    if (rx_en_i) begin
                        if (bus.last_bit) begin
                            bit_cnt  <= '0;
                            byte_cnt <= byte_cnt + 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                sd_dat_pkg::DMA_RX_BYTE_WR: begin
                    if (dma_rx_buf_rdy_i && bus.last_byte)
                        byte_cnt <= '0; // now counts crc bits
                end
                sd_dat_pkg::RX_CRC: begin
                    if (rx_en_i)
                        byte_cnt <= byte_cnt + 1'b1;
                end
                sd_dat_pkg::RX_END_BIT: begin
                    if (rx_en_i)
                        blk_cnt <= blk_cnt + 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign bus.crc_idx   = byte_cnt[IDX_W-1:0];
    assign bus.last_bit  = bit_cnt == (dat_width_i ? 3'd1 : 3'd7);
    assign bus.last_byte = byte_cnt == block_size_i;
    assign bus.last_crc  = bus.crc_idx == IDX_W'(`SD_CRC_LEN - 1);
    assign bus.last_blk  = (block_count_i != '0) && (blk_cnt == block_count_i);

endmodule

`default_nettype wire

// File: src/sd_dat_rx_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sd_dat_rx_fsm (
    input  logic               sd_clk,
    input  logic               rstn,
    input  logic               sd_rst_i,
    input  logic               dat_start_i,
    input  logic               rx_en_i,
    input  logic               dat_width_i,      // 1: 4-bit, 0: 1-bit
    input  sd_dat_pkg::lanes_t dat_i,
    input  logic               dma_rx_buf_rdy_i,
    input  logic               blk_gap_stop_i,
    input  logic               blk_gap_clk_en_i,
    input  logic               read_wait_en_i,
    sd_dat_rx_if.ctrl          bus,
    output logic               busy_o,
    output logic               done_o,
    output logic               blk_gap_o,
    output logic               clk_pause_o,
    output logic               read_wait_o,
    output logic               tmout_rx_start_en_o
);

    sd_dat_pkg::rx_state_e st_q, st_d;
    sd_dat_pkg::lanes_t    act_lanes;
    logic                  start_bit;
    logic                  gap_hold;

    // 1-bit mode only looks at dat0
    assign act_lanes = dat_width_i ? '1 : sd_dat_pkg::lanes_t'(1);
    assign start_bit = (dat_i & act_lanes) == '0;

    // parked at the gap, more blocks to come
    assign gap_hold = (st_q == sd_dat_pkg::RX_BLK_GAP_STOP) && !bus.last_blk && blk_gap_stop_i;

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            st_q <= sd_dat_pkg::IDLE;
        end else if (sd_rst_i) begin
            st_q <= sd_dat_pkg::IDLE;
        end else begin
            st_q <= st_d;
        end
    end

    always_comb begin
        st_d = st_q;
        case (st_q)
            sd_dat_pkg::IDLE: begin
                if (dat_start_i)
                    st_d = sd_dat_pkg::RX_START_BIT;
            end
            sd_dat_pkg::RX_START_BIT: begin
                if (rx_en_i && start_bit)
                    st_d = sd_dat_pkg::RX_DATA_BYTE;
            end
            sd_dat_pkg::RX_DATA_BYTE: begin
                if (rx_en_i && bus.last_bit)
                    st_d = sd_dat_pkg::DMA_RX_BYTE_WR;
            end
            sd_dat_pkg::DMA_RX_BYTE_WR: begin // no strobe needed, clock is stopped
                if (dma_rx_buf_rdy_i)
                    st_d = bus.last_byte ? sd_dat_pkg::RX_CRC : sd_dat_pkg::RX_DATA_BYTE;
            end
            sd_dat_pkg::RX_CRC: begin
                if (rx_en_i && bus.last_crc)
                    st_d = sd_dat_pkg::RX_END_BIT;
            end
            sd_dat_pkg::RX_END_BIT: begin
                if (rx_en_i)
                    st_d = sd_dat_pkg::RX_BLK_GAP_STOP;
            end
            sd_dat_pkg::RX_BLK_GAP_STOP: begin
                if (bus.last_blk)
                    st_d = sd_dat_pkg::IDLE;
                else if (!blk_gap_stop_i)
                    st_d = sd_dat_pkg::RX_START_BIT;
            end
            default: st_d = sd_dat_pkg::IDLE;
        endcase
    end

    // dat2 low asks the card to hold off
    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            read_wait_o <= 1'b0;
        end else if (sd_rst_i) begin
            read_wait_o <= 1'b0;
        end else begin
            read_wait_o <= gap_hold && read_wait_en_i;
        end
    end

    assign bus.state           = st_q;
    assign busy_o              = st_q != sd_dat_pkg::IDLE;
    assign done_o              = (st_q == sd_dat_pkg::RX_BLK_GAP_STOP) && bus.last_blk;
    assign blk_gap_o           = (st_q == sd_dat_pkg::RX_END_BIT) && rx_en_i;
    assign tmout_rx_start_en_o = st_q == sd_dat_pkg::RX_START_BIT;

    // dma wait or gap with clock gated
    assign clk_pause_o = (st_q == sd_dat_pkg::DMA_RX_BYTE_WR) || (gap_hold && !blk_gap_clk_en_i);

endmodule

`default_nettype wire

// File: src/sd_dat_crc16.sv
`timescale 1ns/1ps
`default_nettype none

module sd_dat_crc16 (
    input  logic             sd_clk,
    input  logic             rstn,
    input  logic             clr_i,  // back to zero seed
    input  logic             en_i,
    input  logic             din_i,
    output sd_dat_pkg::crc_t crc_o
);

    localparam sd_dat_pkg::crc_t POLY = 16'h1021; // x^16 + x^12 + x^5 + 1

    logic fb;

    assign fb = din_i ^ crc_o[$bits(crc_o)-1];

    always_ff @(posedge sd_clk or negedge rstn) begin
        if (!rstn) begin
            crc_o <= '0;
        end else if (clr_i) begin
            crc_o <= '0;
        end else if (en_i) begin
            crc_o <= {crc_o[$bits(crc_o)-2:0], 1'b0} ^ (fb ? POLY : '0);
        end
    end

endmodule

`default_nettype wire

// File: src/sd_dat_rx_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "sd_dat_settings.svh"

interface sd_dat_rx_if;

    sd_dat_pkg::rx_state_e state;

    // counter flags
    logic last_bit;   // last bit of a byte
    logic last_byte;  // block_size bytes taken
    logic last_crc;   // last crc bit
    logic last_blk;   // final block of a finite transfer

    logic [$clog2(`SD_CRC_LEN)-1:0] crc_idx; // crc bit position

    modport ctrl (
        output state,
        input  last_bit, last_byte, last_crc, last_blk
    );

    modport cnt (
        input  state,
        output last_bit, last_byte, last_crc, last_blk, crc_idx
    );

    modport data (
        input state, crc_idx
    );

endinterface

`default_nettype wire

// File: src/sd_dat_pkg.sv
`default_nettype none

`include "sd_dat_settings.svh"

package sd_dat_pkg;

    // receive states
    typedef enum logic [2:0] {
        IDLE            = 3'd0,
        RX_START_BIT    = 3'd1, // waiting for card start bit
        RX_DATA_BYTE    = 3'd2,
        DMA_RX_BYTE_WR  = 3'd3, // card clock held here
        RX_CRC          = 3'd4,
        RX_END_BIT      = 3'd5,
        RX_BLK_GAP_STOP = 3'd6
    } rx_state_e;

    typedef logic [`SD_LANES-1:0]   lanes_t;  // one dat sample
    typedef logic [`SD_BYTE_W-1:0]  byte_t;
    typedef logic [`SD_CRC_LEN-1:0] crc_t;
    typedef logic [`SD_CNT_W-1:0]   cnt_t;    // sizes and counters

endpackage

`default_nettype wire

// File: src/sd_dat_settings.svh
`ifndef SD_DAT_SETTINGS_SVH
`define SD_DAT_SETTINGS_SVH

// crc bits per lane
`define SD_CRC_LEN 16

// dat lanes in wide mode
`define SD_LANES 4

`define SD_BYTE_W 8

// block size and block count width
`define SD_CNT_W 16

`endif
